//--- verilog/pov_pkg.sv
package pov_pkg;

  localparam int ROT_RES        = 256;                   // Angular steps per turn
  localparam int HALF_RES       = ROT_RES / 2;           // Steps per half turn
  localparam int DISPLAY_RADIUS = 32;                    // Radial voxel positions
  localparam int DISPLAY_HEIGHT = 16;                    // Voxels per column

  localparam int THETA_W  = $clog2(ROT_RES);             // Angle width
  localparam int RADIUS_W = $clog2(DISPLAY_RADIUS);      // Radius width
  localparam int Z_W      = $clog2(DISPLAY_HEIGHT);      // Height index width
  localparam int ADDR_W   = $clog2(HALF_RES);            // Address into one half turn

  typedef logic [THETA_W-1:0]  theta_t;                  // Top bit picks the half turn
  typedef logic [RADIUS_W-1:0] radius_t;
  typedef logic [Z_W-1:0]      z_t;

  typedef struct packed {
    radius_t                   radius;                   // Tag of last voxel written
    logic [DISPLAY_HEIGHT-1:0] voxels;                   // One bit per z
  } column_t;

  typedef struct packed {
    theta_t  theta;
    radius_t radius;
    z_t      z;
  } voxel_wr_t;

  typedef struct packed {
    theta_t  theta;                                      // Angle of the near arm
    column_t near;                                       // Column at theta
    column_t far;                                        // Column at theta + pi
  } blade_col_t;

  typedef enum logic [1:0] {
    FB_IDLE,                                             // Accepts flush, voxel or read
    FB_FLUSH,                                            // Zeroing both halves
    FB_RMW_WAIT,                                         // Waiting for the old column
    FB_RMW_WRITE                                         // Writing the merged column
  } fb_state_t;

endpackage

//--- verilog/half_turn_ram.sv
`timescale 1ns/1ps

module half_turn_ram #(
  parameter int WIDTH = 21,                              // Column word width
  parameter int DEPTH = 128                              // Entries per half turn
) (
  input  logic                     clk_in,
  input  logic [$clog2(DEPTH)-1:0] addr,                 // Shared read and write address
  input  logic [WIDTH-1:0]         din,
  input  logic                     we,
  output logic [WIDTH-1:0]         dout                  // Valid 2 cycles after addr
);

  logic [WIDTH-1:0] mem [DEPTH];                         // Block RAM array
  logic [WIDTH-1:0] rd_stage;                            // First output register

  // Read-first port keeps the old word when a write lands on the same address
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[addr] <= din;                                  // Write takes effect at this edge
    end
    rd_stage <= mem[addr];                               // Old contents on a collision
  end

  // Second register stage as in a high-performance block RAM
  always_ff @(posedge clk_in) begin
    dout <= rd_stage;
  end

endmodule

//--- verilog/rot_frame_buffer.sv
`timescale 1ns/1ps

module rot_frame_buffer import pov_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      flush,                               // Clear both halves
  input  logic      voxel_valid,                         // New voxel strobe
  input  voxel_wr_t voxel,
  output logic      busy,                                // Writers must wait while high
  input  logic      rd_req,                              // Held until rd_valid
  input  theta_t    rd_theta,                            // Stable while rd_req
  output logic      rd_valid,                            // Column pair strobe
  output column_t   rd_near,                             // Column at rd_theta
  output column_t   rd_far                               // Column at rd_theta + pi
);

  typedef struct packed {
    logic vld;                                           // Read issued
    logic half;                                          // Top theta bit of that read
  } rd_tag_t;

  fb_state_t                 state;
  logic [ADDR_W-1:0]         flush_addr;                 // Zeroed entry in FB_FLUSH
  logic                      rmw_cnt;                    // Second wait cycle marker
  voxel_wr_t                 wr_voxel;                   // Voxel held for the RMW
  column_t                   new_col;                    // Merged word to store
  column_t                   old_col;                    // Stored word at wr_voxel.theta
  logic [DISPLAY_HEIGHT-1:0] z_bit;                      // One-hot height of new voxel
  rd_tag_t [1:0]             rd_pipe;                    // Tracks reads through the RAM

  logic              flush_acc;
  logic              voxel_acc;
  logic              rd_issue;
  logic              wr_half;                            // Half turn of the pending write
  logic [ADDR_W-1:0] ram_addr;                           // Shared by both halves
  column_t           ram_din;
  logic              we_lo;
  logic              we_hi;
  column_t           lo_q;                               // 0..pi output
  column_t           hi_q;                               // pi..2pi output

  assign busy      = (state != FB_IDLE);
  assign flush_acc = (state == FB_IDLE) && flush;        // Flush wins over a voxel
  assign voxel_acc = (state == FB_IDLE) && voxel_valid && !flush;
  assign rd_issue  = (state == FB_IDLE) && !flush && !voxel_valid && rd_req &&
                     !rd_pipe[0].vld && !rd_pipe[1].vld; // One read in flight at most
  assign wr_half   = wr_voxel.theta[THETA_W-1];

  // Address source by state
  always_comb begin
    ram_addr = rd_theta[ADDR_W-1:0];                     // Idle default is the read
    case (state)
      FB_FLUSH: ram_addr = flush_addr;
      FB_RMW_WAIT, FB_RMW_WRITE: ram_addr = wr_voxel.theta[ADDR_W-1:0];
      default: begin
        if (voxel_valid) begin
          ram_addr = voxel.theta[ADDR_W-1:0];            // RMW read starts at once
        end
      end
    endcase
  end

  assign ram_din = (state == FB_FLUSH) ? '0 : new_col;
  assign we_lo   = (state == FB_FLUSH) || ((state == FB_RMW_WRITE) && !wr_half);
  assign we_hi   = (state == FB_FLUSH) || ((state == FB_RMW_WRITE) && wr_half);

  half_turn_ram #(
    .WIDTH ($bits(column_t)),
    .DEPTH (HALF_RES)
  ) ram_lo (
    .clk_in (clk_in),
    .addr   (ram_addr),
    .din    (ram_din),
    .we     (we_lo),
    .dout   (lo_q)
  );

  half_turn_ram #(
    .WIDTH ($bits(column_t)),
    .DEPTH (HALF_RES)
  ) ram_hi (
    .clk_in (clk_in),
    .addr   (ram_addr),
    .din    (ram_din),
    .we     (we_hi),
    .dout   (hi_q)
  );

  // Merge of the old column with the new voxel
  always_comb begin
    old_col       = wr_half ? hi_q : lo_q;
    z_bit         = '0;
    z_bit[wr_voxel.z] = 1'b1;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= FB_IDLE;
      flush_addr <= '0;
      rmw_cnt    <= 1'b0;
    end else begin
      case (state)
        FB_IDLE: begin
          if (flush_acc) begin
            state      <= FB_FLUSH;
            flush_addr <= '0;                            // Entry 0 cleared next cycle
          end else if (voxel_acc) begin
            state   <= FB_RMW_WAIT;
            rmw_cnt <= 1'b0;
          end
        end
        FB_FLUSH: begin
          flush_addr <= flush_addr + 1'b1;
          if (flush_addr == ADDR_W'(HALF_RES - 1)) begin
            state <= FB_IDLE;                            // Last entry cleared
          end
        end
        FB_RMW_WAIT: begin
          rmw_cnt <= 1'b1;
          if (rmw_cnt) begin
            state <= FB_RMW_WRITE;                       // Old word merged this cycle
          end
        end
        default: state <= FB_IDLE;                       // Write lands in FB_RMW_WRITE
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (voxel_acc) begin
      wr_voxel <= voxel;
    end
    if ((state == FB_RMW_WAIT) && rmw_cnt) begin
      new_col.radius <= wr_voxel.radius;                 // Tag follows the last writer
      new_col.voxels <= old_col.voxels | z_bit;
    end
  end

  // Read tracking beside the RAM pipeline
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe[0].vld  <= rd_issue;
      rd_pipe[0].half <= rd_theta[THETA_W-1];
      rd_pipe[1]      <= rd_pipe[0];
    end
  end

  assign rd_valid = rd_pipe[1].vld;
  assign rd_near  = rd_pipe[1].half ? hi_q : lo_q;       // Half of theta is near
  assign rd_far   = rd_pipe[1].half ? lo_q : hi_q;

  a_no_strobe_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    busy |-> !(voxel_valid || flush));

  a_rd_valid_gap: assert property (@(posedge clk_in) disable iff (rst_in)
    rd_valid |=> !rd_valid);

endmodule

//--- verilog/angle_tracker.sv
`timescale 1ns/1ps

module angle_tracker import pov_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   enc_step,                               // One angular step
  input  logic   enc_index,                              // Zero mark of the encoder
  output logic   angle_step,                             // New angle strobe
  output theta_t angle
);

  // Count wraps naturally at ROT_RES since theta_t is log2 wide
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      angle      <= '0;
      angle_step <= 1'b0;
    end else begin
      angle_step <= enc_step || enc_index;
      if (enc_index) begin
        angle <= '0;                                     // Index beats step
      end else if (enc_step) begin
        angle <= angle + 1'b1;
      end
    end
  end

  // Index may only correct a small slip around the wrap
  a_index_near_wrap: assert property (@(posedge clk_in) disable iff (rst_in)
    enc_index |-> ((angle >= theta_t'(ROT_RES - 2)) || (angle <= theta_t'(2))));

endmodule

//--- verilog/blade_driver.sv
`timescale 1ns/1ps

module blade_driver import pov_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       angle_step,                         // Blade reached a new angle
  input  theta_t     angle,
  output logic       rd_req,                             // Pending column pair fetch
  output theta_t     rd_theta,
  input  logic       rd_valid,
  input  column_t    rd_near,
  input  column_t    rd_far,
  output logic       col_valid,                          // Blade word strobe
  output blade_col_t blade_col
);

  // Request handshake with the frame buffer
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_req    <= 1'b0;
      col_valid <= 1'b0;
    end else begin
      col_valid <= rd_valid;                             // One cycle behind the data
      if (rd_valid) begin
        rd_req <= 1'b0;
      end
      if (angle_step) begin
        rd_req <= 1'b1;                                  // New angle opens a request
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (angle_step) begin
      rd_theta <= angle;                                 // Latest angle wins
    end
    if (rd_valid) begin
      blade_col.theta <= rd_theta;
      blade_col.near  <= rd_near;
      blade_col.far   <= rd_far;
    end
  end

  // Request must not be retargeted while the buffer may be reading it
  a_step_while_pending: assert property (@(posedge clk_in) disable iff (rst_in)
    angle_step |-> !rd_req);

endmodule

//--- verilog/pov_display_top.sv
`timescale 1ns/1ps

module pov_display_top import pov_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       voxel_valid,                        // Only while busy is low
  input  voxel_wr_t  voxel,
  input  logic       flush,                              // Only while busy is low
  output logic       busy,
  input  logic       enc_step,
  input  logic       enc_index,
  output logic       col_valid,
  output blade_col_t blade_col
);

  logic    angle_step;                                   // Tracker to driver
  theta_t  angle;
  logic    rd_req;                                       // Driver to buffer
  theta_t  rd_theta;
  logic    rd_valid;                                     // Buffer back to driver
  column_t rd_near;
  column_t rd_far;

  angle_tracker u_angle_tracker (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .enc_step   (enc_step),
    .enc_index  (enc_index),
    .angle_step (angle_step),
    .angle      (angle)
  );

  blade_driver u_blade_driver (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .angle_step (angle_step),
    .angle      (angle),
    .rd_req     (rd_req),
    .rd_theta   (rd_theta),
    .rd_valid   (rd_valid),
    .rd_near    (rd_near),
    .rd_far     (rd_far),
    .col_valid  (col_valid),
    .blade_col  (blade_col)
  );

  rot_frame_buffer u_rot_frame_buffer (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .flush       (flush),
    .voxel_valid (voxel_valid),
    .voxel       (voxel),
    .busy        (busy),
    .rd_req      (rd_req),
    .rd_theta    (rd_theta),
    .rd_valid    (rd_valid),
    .rd_near     (rd_near),
    .rd_far      (rd_far)
  );

endmodule

//--- dv/pov_display_tb.sv
`timescale 1ns/1ps

module pov_display_tb import pov_pkg::*; ();

  localparam int     RAND_WRITES  = 200;                 // Random voxels in the mixed run
  localparam int     RAND_STEPS   = 300;                 // Random steps in the mixed run
  localparam int     STEP_BUDGET  = 3 * ROT_RES + RAND_STEPS + 8;
  localparam int     WRITE_BUDGET = RAND_WRITES + 6;
  localparam int     CYCLE_LIMIT  = 4 * HALF_RES + 8 * (STEP_BUDGET + WRITE_BUDGET) + 500;
  localparam theta_t HALF_FLIP    = theta_t'(HALF_RES);  // Top theta bit

  logic       clk_in = 1'b0;
  logic       rst_in;
  logic       voxel_valid;
  voxel_wr_t  voxel;
  logic       flush;
  logic       busy;
  logic       enc_step;
  logic       enc_index;
  logic       col_valid;
  blade_col_t blade_col;

  column_t     model_mem [ROT_RES];                      // Expected column per theta
  theta_t      angle_mirror;                             // Expected tracker angle
  logic        req_open;                                 // Own angle request outstanding
  logic [31:0] lfsr_state;
  int          cycle_cnt;

  pov_display_top dut (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .voxel_valid (voxel_valid),
    .voxel       (voxel),
    .flush       (flush),
    .busy        (busy),
    .enc_step    (enc_step),
    .enc_index   (enc_index),
    .col_valid   (col_valid),
    .blade_col   (blade_col)
  );

  always #5 clk_in = ~clk_in;                            // 10 ns period

  always @(posedge clk_in) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("test failed");
      $fatal(1, "timeout after %0d cycles", cycle_cnt);
    end
  end

  // Strobe with nothing requested means a stray read
  always @(negedge clk_in) begin
    if (!rst_in && col_valid && !req_open) begin
      $display("test failed");
      $fatal(1, "col_valid at %0t without an outstanding angle request", $time);
    end
  end

  task automatic compare_values(input string name, input logic [63:0] exp_val,
                                input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp_val, act_val);
      $display("test failed");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);                // One step per bit
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic random_voxel(output voxel_wr_t v);
    logic [31:0] r;
    take_bits(THETA_W, r);
    v.theta = r[THETA_W-1:0];                            // Spans both halves
    take_bits(RADIUS_W, r);
    v.radius = r[RADIUS_W-1:0];
    take_bits(Z_W, r);
    v.z = r[Z_W-1:0];
  endtask

  task automatic write_voxel(input voxel_wr_t v);
    int busy_cnt;
    @(posedge clk_in);
    voxel_valid <= 1'b1;
    voxel       <= v;
    model_mem[v.theta].voxels[v.z] = 1'b1;               // OR in the new bit
    model_mem[v.theta].radius      = v.radius;           // Last writer owns the tag
    @(negedge clk_in);
    compare_values("busy at voxel accept", 64'd0, 64'(busy));
    @(posedge clk_in);
    voxel_valid <= 1'b0;
    busy_cnt = 0;
    @(negedge clk_in);
    while (busy) begin
      busy_cnt++;
      @(negedge clk_in);
    end
    compare_values("busy cycles per write", 64'd3, 64'(busy_cnt));
  endtask

  task automatic flush_frame();
    int busy_cnt;
    @(posedge clk_in);
    flush <= 1'b1;
    for (int i = 0; i < ROT_RES; i++) begin
      model_mem[i] = '0;
    end
    @(negedge clk_in);
    compare_values("busy at flush accept", 64'd0, 64'(busy));
    @(posedge clk_in);
    flush <= 1'b0;
    busy_cnt = 0;
    @(negedge clk_in);
    while (busy) begin
      busy_cnt++;
      @(negedge clk_in);
    end
    compare_values("busy cycles per flush", 64'(HALF_RES), 64'(busy_cnt));
  endtask

  task automatic check_column(input logic expect_zero);
    compare_values("blade_col.theta", 64'(angle_mirror), 64'(blade_col.theta));
    compare_values("blade_col.near", 64'(model_mem[angle_mirror]), 64'(blade_col.near));
    compare_values("blade_col.far", 64'(model_mem[angle_mirror ^ HALF_FLIP]),
                   64'(blade_col.far));
    if (expect_zero) begin
      compare_values("cleared near", 64'd0, 64'(blade_col.near));
      compare_values("cleared far", 64'd0, 64'(blade_col.far));
    end
  endtask

  // One encoder strobe, then wait for its column pair
  task automatic step_and_check(input logic use_index, input logic expect_zero);
    @(posedge clk_in);
    if (use_index) begin
      enc_index    <= 1'b1;
      angle_mirror = '0;                                 // Index resyncs to zero
    end else begin
      enc_step     <= 1'b1;
      angle_mirror = angle_mirror + theta_t'(1);         // Wraps at ROT_RES
    end
    req_open = 1'b1;
    @(posedge clk_in);
    enc_step  <= 1'b0;
    enc_index <= 1'b0;
    @(negedge clk_in);
    while (!col_valid) begin
      @(negedge clk_in);
    end
    check_column(expect_zero);
    @(posedge clk_in);
    req_open = 1'b0;                                     // Strobe is over by now
  endtask

  initial begin
    voxel_wr_t   v;
    logic [31:0] r;
    int          writes_left;
    int          steps_left;
    rst_in       = 1'b1;
    voxel_valid  = 1'b0;
    voxel        = '0;
    flush        = 1'b0;
    enc_step     = 1'b0;
    enc_index    = 1'b0;
    angle_mirror = '0;
    req_open     = 1'b0;
    lfsr_state   = 32'h52;
    cycle_cnt    = 0;
    repeat (10) @(posedge clk_in);
    rst_in <= 1'b0;

    repeat (20) begin                                    // Quiet outputs before stimulus
      @(negedge clk_in);
      compare_values("busy after reset", 64'd0, 64'(busy));
      compare_values("col_valid after reset", 64'd0, 64'(col_valid));
    end

    flush_frame();                                       // Clear, then a full zero turn
    repeat (ROT_RES) step_and_check(1'b0, 1'b1);

    v = '{theta: 8'h83, radius: 5'd3, z: 4'd1};          // Accumulate in the far half
    write_voxel(v);
    v = '{theta: 8'h83, radius: 5'd17, z: 4'd7};
    write_voxel(v);
    v = '{theta: 8'h83, radius: 5'd29, z: 4'd12};
    write_voxel(v);
    v = '{theta: 8'h03, radius: 5'd9, z: 4'd0};
    write_voxel(v);
    repeat (3) step_and_check(1'b0, 1'b0);
    compare_values("far tag after OR", 64'd29, 64'(blade_col.far.radius));
    compare_values("far voxels after OR", 64'h1082, 64'(blade_col.far.voxels));
    compare_values("near voxels at 3", 64'h0001, 64'(blade_col.near.voxels));

    writes_left = RAND_WRITES;
    steps_left  = RAND_STEPS;
    while ((writes_left > 0) || (steps_left > 0)) begin
      take_bits(1, r);
      if ((writes_left > 0) && (r[0] || (steps_left == 0))) begin
        random_voxel(v);
        write_voxel(v);
        writes_left--;
      end else begin
        step_and_check(1'b0, 1'b0);
        steps_left--;
      end
    end

    while (angle_mirror != theta_t'(ROT_RES - 2)) begin  // Run up to just before the wrap
      step_and_check(1'b0, 1'b0);
    end
    step_and_check(1'b1, 1'b0);                          // Index instead of the next step
    compare_values("theta after index", 64'd0, 64'(blade_col.theta));
    step_and_check(1'b0, 1'b0);

    flush_frame();                                       // Second clear over a full turn
    repeat (ROT_RES) step_and_check(1'b0, 1'b1);

    $display("test passed");
    $finish;
  end

endmodule

//--- filelist.f
verilog/pov_pkg.sv
verilog/half_turn_ram.sv
verilog/rot_frame_buffer.sv
verilog/angle_tracker.sv
verilog/blade_driver.sv
verilog/pov_display_top.sv
dv/pov_display_tb.sv

//--- Makefile
TOP = pov_display_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f verilog/*.sv dv/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
